// ==== dv/stimulus_ooo.txt ====
# op rd rs1 rs2 imm use_imm exp_rd exp_value, all hex
# op codes: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 sll, 6 srl, 7 slt
0 01 00 00 12345678 1 01 12345678
0 02 00 00 0000000f 1 02 0000000f
0 03 00 00 fffffff0 1 03 fffffff0
1 04 01 02 00000000 0 04 12345669
2 05 01 00 0000ff00 1 05 00005600
3 06 02 03 00000000 0 06 ffffffff
4 07 01 03 00000000 0 07 edcba988
5 08 02 00 00000004 1 08 000000f0
6 09 03 00 00000004 1 09 0fffffff
7 0a 03 02 00000000 0 0a 00000001
7 0b 02 03 00000000 0 0b 00000000
0 00 01 02 00000000 0 00 12345687
0 0c 00 02 00000000 0 0c 0000000f
5 0d 01 02 00000000 0 0d 2b3c0000
0 0e 01 00 00000001 1 0e 12345679
0 0e 0e 00 00000001 1 0e 1234567a
0 0e 0e 00 00000001 1 0e 1234567b
0 0e 0e 0e 00000000 0 0e 2468acf6
1 0e 0e 02 00000000 0 0e 2468ace7
4 0e 0e 01 00000000 0 0e 365cfa9f
6 0e 0e 00 00000003 1 0e 06cb9f53
3 0e 0e 03 00000000 0 0e fffffff3
2 0f 0e 09 00000000 0 0f 0ffffff3
7 10 0e 00 00000000 0 10 00000001
0 11 10 0f 00000000 0 11 0ffffff4
1 00 11 10 00000000 0 00 0ffffff3
0 12 00 11 00000000 0 12 0ffffff4
0 12 12 12 00000000 0 12 1fffffe8

// ==== dv/tb_ooo_core.sv ====
////////////////////////////////////////////////////////////
// testbench for ooo_core, replays the stimulus program and
// checks every commit against the expected rd and value
////////////////////////////////////////////////////////////
module tb_ooo_core;
  timeunit 1ns;
  timeprecision 1ps;
  import ooo_pkg::*;

  // lines from this index on issue back to back
  localparam int BURST_FROM  = 14;
  localparam int FULL_LIMIT  = 200;
  localparam int DRAIN_LIMIT = 500;

  logic        clk_in;
  logic        rst;
  issue_req_t  issue;
  logic        issue_full;
  commit_t     commit;

  issue_req_t  prog_q    [$];
  logic [4:0]  exp_rd_q  [$];
  logic [31:0] exp_val_q [$];
  int          n_lines;
  int          issued;
  int          commits_seen;
  int          errors;
  bit          full_seen;
  bit          aborted;
  bit          ok;
  logic [31:0] lcg_state;
  logic [1:0]  gap;

  ooo_core u_ooo_core (
    .clk_in    (clk_in),
    .rst       (rst),
    .issue     (issue),
    .issue_full(issue_full),
    .commit    (commit)
  );

  always #4 clk_in = ~clk_in;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // comment and blank lines fail the scan and are skipped
  task automatic load_program();
    int          fd;
    int          cnt;
    string       line;
    logic [31:0] fld [8];
    issue_req_t  req;
    fd = $fopen("dv/stimulus_ooo.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the stimulus file dv/stimulus_ooo.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        cnt = $sscanf(line, "%h %h %h %h %h %h %h %h", fld[0], fld[1], fld[2], fld[3],
                      fld[4], fld[5], fld[6], fld[7]);
        if (cnt == 8) begin
          req.valid   = 1'b1;
          req.op      = alu_op_e'(fld[0][2:0]);
          req.rd      = fld[1][4:0];
          req.rs1     = fld[2][4:0];
          req.rs2     = fld[3][4:0];
          req.imm     = fld[4];
          req.use_imm = fld[5][0];
          prog_q.push_back(req);
          exp_rd_q.push_back(fld[6][4:0]);
          exp_val_q.push_back(fld[7]);
        end
      end
      $fclose(fd);
    end
    n_lines = prog_q.size();
  endtask

  task automatic wait_not_full(output bit done);
    int cnt;
    cnt = 0;
    while (issue_full && cnt < FULL_LIMIT) begin
      @(negedge clk_in);
      cnt++;
    end
    done = !issue_full;
    if (!done) begin
      errors++;
      $display("timeout, issue_full stayed high before instruction %0d", issued);
    end
  endtask

  task automatic wait_for_commits(output bit done);
    int cnt;
    cnt = 0;
    while (commits_seen < n_lines && cnt < DRAIN_LIMIT) begin
      @(negedge clk_in);
      cnt++;
    end
    done = commits_seen >= n_lines;
    if (!done) begin
      errors++;
      $display("timeout, only %0d of %0d instructions committed", commits_seen, n_lines);
    end
  endtask

  // commit only moves on clock edges, so the falling edge sees it settled
  always @(negedge clk_in) begin
    if (!rst) begin
      if (issue_full) begin
        full_seen = 1'b1;
      end
      if (issued == 0) begin
        assert (!commit.valid) else begin
          errors++;
          $display("commit strobe seen before any instruction was issued");
        end
        assert (!issue_full) else begin
          errors++;
          $display("issue_full high before any instruction was issued");
        end
      end
      if (commit.valid) begin
        assert (commits_seen < n_lines) else begin
          errors++;
          $display("extra commit after all %0d instructions retired", n_lines);
        end
        if (commits_seen < n_lines) begin
          assert (commit.rd == exp_rd_q[commits_seen]) else begin
            errors++;
            $display("FAILED commit.rd at commit %0d: got %h, expected %h",
                     commits_seen, commit.rd, exp_rd_q[commits_seen]);
          end
          assert (commit.value == exp_val_q[commits_seen]) else begin
            errors++;
            $display("FAILED commit.value at commit %0d: got %h, expected %h",
                     commits_seen, commit.value, exp_val_q[commits_seen]);
          end
        end
        commits_seen++;
      end
    end
  end

  initial begin
    clk_in       = 1'b0;
    rst          = 1'b1;
    issue        = '0;
    issued       = 0;
    commits_seen = 0;
    errors       = 0;
    full_seen    = 1'b0;
    aborted      = 1'b0;
    lcg_state    = 32'hfef13d5a;
    load_program();
    repeat (4) @(negedge clk_in);
    rst = 1'b0;
    if (n_lines == 0) begin
      errors++;
      aborted = 1'b1;
      $display("no instructions were read from the stimulus file");
    end
    for (int i = 0; i < n_lines && !aborted; i++) begin
      if (i < BURST_FROM) begin
        lcg_state = lcg_next(lcg_state);
        gap       = lcg_state[17:16];
        repeat (gap) @(negedge clk_in);
      end
      wait_not_full(ok);
      if (!ok) begin
        aborted = 1'b1;
      end else begin
        issue = prog_q[i];
        issued++;
        @(negedge clk_in);
        issue.valid = 1'b0;
      end
    end
    if (!aborted) begin
      wait_for_commits(ok);
      // a few idle cycles to catch a duplicated commit
      repeat (4) @(negedge clk_in);
      assert (full_seen) else begin
        errors++;
        $display("issue_full never went high during the back-to-back burst");
      end
      assert (commits_seen == n_lines) else begin
        errors++;
        $display("saw %0d commits for %0d instructions", commits_seen, n_lines);
      end
    end
    $display("%0d issued, %0d committed, %0d errors", issued, commits_seen, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
verilog/ooo_pkg.sv
verilog/int_alu.sv
verilog/reorder_buffer.sv
verilog/rename_regfile.sv
verilog/reservation_station.sv
verilog/ooo_core.sv
dv/tb_ooo_core.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_ooo_core \
  -Mdir obj_dir -o tb_ooo_core > build.log 2>&1 \
  && ./obj_dir/tb_ooo_core > sim.log 2>&1 \
  || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -qx "NO ERRORS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

// ==== verilog/int_alu.sv ====
////////////////////////////////////////////////////////////
// single-cycle integer alu, result lands on the cdb next cycle
////////////////////////////////////////////////////////////
module int_alu (
  input  logic              clk_in,
  input  logic              rst,
  input  ooo_pkg::alu_req_t alu_req,
  output ooo_pkg::cdb_t     cdb
);
  import ooo_pkg::*;

  logic [XLEN-1:0]  result;
  logic             out_valid;
  logic [TAG_W-1:0] out_tag;
  logic [XLEN-1:0]  out_value;

  always_comb begin
    case (alu_req.op)
      op_add:  result = alu_req.a + alu_req.b;
      op_sub:  result = alu_req.a - alu_req.b;
      op_and:  result = alu_req.a & alu_req.b;
      op_or:   result = alu_req.a | alu_req.b;
      op_xor:  result = alu_req.a ^ alu_req.b;
      // shift amount from the low 5 bits only
      op_sll:  result = alu_req.a << alu_req.b[4:0];
      op_srl:  result = alu_req.a >> alu_req.b[4:0];
      op_slt:  result = XLEN'($signed(alu_req.a) < $signed(alu_req.b));
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= alu_req.valid;
    end
  end

  always_ff @(posedge clk_in) begin
    out_tag   <= alu_req.tag;
    out_value <= result;
  end

  assign cdb = '{valid: out_valid, tag: out_tag, value: out_value};

endmodule

// ==== verilog/ooo_core.sv ====
////////////////////////////////////////////////////////////
// out-of-order integer core, issue strobe in, commit strobe out
// source must hold off issuing while issue_full is high
////////////////////////////////////////////////////////////
module ooo_core (
  input  logic                clk_in,
  input  logic                rst,
  input  ooo_pkg::issue_req_t issue,
  output logic                issue_full,
  output ooo_pkg::commit_t    commit
);
  import ooo_pkg::*;

  issue_req_t       issue_acc;
  logic [TAG_W-1:0] alloc_tag;
  logic             rob_full;
  logic             rs_full;
  logic [TAG_W-1:0] query_tag1;
  logic [TAG_W-1:0] query_tag2;
  logic             query_ready1;
  logic             query_ready2;
  logic [XLEN-1:0]  query_value1;
  logic [XLEN-1:0]  query_value2;
  operand_t         src1;
  operand_t         src2;
  alu_req_t         alu_req;
  cdb_t             cdb;

  assign issue_full = rob_full | rs_full;

  // drop a strobe that arrives while either structure is full
  always_comb begin
    issue_acc       = issue;
    issue_acc.valid = issue.valid & ~issue_full;
  end

  rename_regfile u_rename_regfile (
    .clk_in      (clk_in),
    .rst         (rst),
    .issue       (issue_acc),
    .alloc_tag   (alloc_tag),
    .query_tag1  (query_tag1),
    .query_tag2  (query_tag2),
    .query_ready1(query_ready1),
    .query_ready2(query_ready2),
    .query_value1(query_value1),
    .query_value2(query_value2),
    .src1        (src1),
    .src2        (src2),
    .commit      (commit)
  );

  reorder_buffer u_reorder_buffer (
    .clk_in      (clk_in),
    .rst         (rst),
    .issue       (issue_acc),
    .alloc_tag   (alloc_tag),
    .full        (rob_full),
    .query_tag1  (query_tag1),
    .query_tag2  (query_tag2),
    .query_ready1(query_ready1),
    .query_ready2(query_ready2),
    .query_value1(query_value1),
    .query_value2(query_value2),
    .cdb         (cdb),
    .commit      (commit)
  );

  reservation_station u_reservation_station (
    .clk_in   (clk_in),
    .rst      (rst),
    .issue    (issue_acc),
    .src1     (src1),
    .src2     (src2),
    .alloc_tag(alloc_tag),
    .cdb      (cdb),
    .full     (rs_full),
    .alu_req  (alu_req)
  );

  int_alu u_int_alu (
    .clk_in (clk_in),
    .rst    (rst),
    .alu_req(alu_req),
    .cdb    (cdb)
  );

endmodule

// ==== verilog/ooo_pkg.sv ====
////////////////////////////////////////////////////////////
// widths, opcodes and bus structs shared by the ooo core
// compile this package ahead of every rtl file
////////////////////////////////////////////////////////////
package ooo_pkg;

  localparam int XLEN      = 32;
  localparam int REG_COUNT = 32;
  localparam int REG_W     = 5;
  // rob index doubles as the rename tag
  localparam int ROB_DEPTH = 8;
  localparam int TAG_W     = 3;
  localparam int RS_DEPTH  = 4;

  typedef enum logic [2:0] {
    op_add = 3'd0,
    op_sub = 3'd1,
    op_and = 3'd2,
    op_or  = 3'd3,
    op_xor = 3'd4,
    op_sll = 3'd5,
    op_srl = 3'd6,
    op_slt = 3'd7
  } alu_op_e;

  // decoded instruction, imm replaces rs2 when use_imm is set
  typedef struct packed {
    logic             valid;
    alu_op_e          op;
    logic [REG_W-1:0] rd;
    logic [REG_W-1:0] rs1;
    logic [REG_W-1:0] rs2;
    logic [XLEN-1:0]  imm;
    logic             use_imm;
  } issue_req_t;

  // tag names the producer while ready is low
  typedef struct packed {
    logic             ready;
    logic [TAG_W-1:0] tag;
    logic [XLEN-1:0]  value;
  } operand_t;

  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
    logic [XLEN-1:0]  value;
  } cdb_t;

  typedef struct packed {
    logic             valid;
    alu_op_e          op;
    logic [TAG_W-1:0] tag;
    logic [XLEN-1:0]  a;
    logic [XLEN-1:0]  b;
  } alu_req_t;

  typedef struct packed {
    logic             valid;
    logic [REG_W-1:0] rd;
    logic [XLEN-1:0]  value;
  } commit_t;

endpackage

// ==== verilog/rename_regfile.sv ====
////////////////////////////////////////////////////////////
// architectural registers with rename tags
// turns rs1/rs2 into operands, with help from the rob query
////////////////////////////////////////////////////////////
module rename_regfile (
  input  logic                      clk_in,
  input  logic                      rst,
  input  ooo_pkg::issue_req_t       issue,
  input  logic [ooo_pkg::TAG_W-1:0] alloc_tag,
  output logic [ooo_pkg::TAG_W-1:0] query_tag1,
  output logic [ooo_pkg::TAG_W-1:0] query_tag2,
  input  logic                      query_ready1,
  input  logic                      query_ready2,
  input  logic [ooo_pkg::XLEN-1:0]  query_value1,
  input  logic [ooo_pkg::XLEN-1:0]  query_value2,
  output ooo_pkg::operand_t         src1,
  output ooo_pkg::operand_t         src2,
  input  ooo_pkg::commit_t          commit
);
  import ooo_pkg::*;

  logic [XLEN-1:0]      regs     [REG_COUNT];
  logic [TAG_W-1:0]     pend_tag [REG_COUNT];
  logic [REG_COUNT-1:0] pend_valid;
  // tracks the rob head, retirement is strictly in order
  logic [TAG_W-1:0]     retire_tag;

  // register value, or the rob answer when renamed
  function automatic operand_t resolve(input logic [REG_W-1:0] idx,
                                       input logic             q_ready,
                                       input logic [XLEN-1:0]  q_value);
    operand_t res;
    res.ready = 1'b1;
    res.tag   = '0;
    res.value = regs[idx];
    if (pend_valid[idx]) begin
      res.ready = q_ready;
      res.tag   = pend_tag[idx];
      res.value = q_ready ? q_value : '0;
    end
    return res;
  endfunction

  assign query_tag1 = pend_tag[issue.rs1];
  assign query_tag2 = pend_tag[issue.rs2];
  assign src1       = resolve(issue.rs1, query_ready1, query_value1);
  assign src2       = resolve(issue.rs2, query_ready2, query_value2);

  always_ff @(posedge clk_in) begin
    if (rst) begin
      pend_valid <= '0;
      retire_tag <= '0;
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (commit.valid) begin
        retire_tag <= retire_tag + 1'b1;
        if (commit.rd != '0) begin
          regs[commit.rd] <= commit.value;
        end
        // a younger writer keeps its rename
        if (pend_tag[commit.rd] == retire_tag) begin
          pend_valid[commit.rd] <= 1'b0;
        end
      end
      // new rename wins over a clear in the same cycle
      if (issue.valid && issue.rd != '0) begin
        pend_valid[issue.rd] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (issue.valid && issue.rd != '0) begin
      pend_tag[issue.rd] <= alloc_tag;
    end
  end

endmodule

// ==== verilog/reorder_buffer.sv ====
////////////////////////////////////////////////////////////
// reorder buffer, allocates tags at issue, retires in order
// also answers operand queries by tag for the rename stage
////////////////////////////////////////////////////////////
module reorder_buffer (
  input  logic                      clk_in,
  input  logic                      rst,
  input  ooo_pkg::issue_req_t       issue,
  output logic [ooo_pkg::TAG_W-1:0] alloc_tag,
  output logic                      full,
  input  logic [ooo_pkg::TAG_W-1:0] query_tag1,
  input  logic [ooo_pkg::TAG_W-1:0] query_tag2,
  output logic                      query_ready1,
  output logic                      query_ready2,
  output logic [ooo_pkg::XLEN-1:0]  query_value1,
  output logic [ooo_pkg::XLEN-1:0]  query_value2,
  input  ooo_pkg::cdb_t             cdb,
  output ooo_pkg::commit_t          commit
);
  import ooo_pkg::*;

  logic [REG_W-1:0]     ent_rd    [ROB_DEPTH];
  logic [XLEN-1:0]      ent_value [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] ent_done;
  logic [TAG_W-1:0]     head;
  logic [TAG_W-1:0]     tail;
  logic [TAG_W:0]       count;
  operand_t             ans1;
  operand_t             ans2;

  // written result, or one on the cdb right now
  function automatic operand_t lookup(input logic [TAG_W-1:0] tag);
    operand_t res;
    res.tag   = tag;
    res.ready = ent_done[tag];
    res.value = ent_value[tag];
    if (!ent_done[tag] && cdb.valid && cdb.tag == tag) begin
      res.ready = 1'b1;
      res.value = cdb.value;
    end
    return res;
  endfunction

  assign ans1         = lookup(query_tag1);
  assign ans2         = lookup(query_tag2);
  assign query_ready1 = ans1.ready;
  assign query_value1 = ans1.value;
  assign query_ready2 = ans2.ready;
  assign query_value2 = ans2.value;

  assign alloc_tag = tail;
  assign full      = count == (TAG_W + 1)'(ROB_DEPTH);

  always_comb begin
    commit.valid = (count != '0) && ent_done[head];
    commit.rd    = ent_rd[head];
    commit.value = ent_value[head];
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (issue.valid) begin
        tail <= tail + 1'b1;
      end
      if (commit.valid) begin
        head <= head + 1'b1;
      end
      count <= count + (TAG_W + 1)'(issue.valid) - (TAG_W + 1)'(commit.valid);
    end
  end

  always_ff @(posedge clk_in) begin
    if (issue.valid) begin
      ent_rd[tail]   <= issue.rd;
      ent_done[tail] <= 1'b0;
    end
    if (cdb.valid) begin
      ent_done[cdb.tag]  <= 1'b1;
      ent_value[cdb.tag] <= cdb.value;
    end
  end

endmodule

// ==== verilog/reservation_station.sv ====
////////////////////////////////////////////////////////////
// alu reservation station, wakes slots from the cdb
// dispatches the oldest ready slot each cycle
////////////////////////////////////////////////////////////
module reservation_station (
  input  logic                      clk_in,
  input  logic                      rst,
  input  ooo_pkg::issue_req_t       issue,
  input  ooo_pkg::operand_t         src1,
  input  ooo_pkg::operand_t         src2,
  input  logic [ooo_pkg::TAG_W-1:0] alloc_tag,
  input  ooo_pkg::cdb_t             cdb,
  output logic                      full,
  output ooo_pkg::alu_req_t         alu_req
);
  import ooo_pkg::*;

  localparam int IDX_W = $clog2(RS_DEPTH);

  logic [RS_DEPTH-1:0] slot_valid;
  alu_op_e             slot_op    [RS_DEPTH];
  logic [TAG_W-1:0]    slot_tag   [RS_DEPTH];
  operand_t            slot_a     [RS_DEPTH];
  operand_t            slot_b     [RS_DEPTH];
  // bit j of row i set when slot j was issued before slot i
  logic [RS_DEPTH-1:0] slot_older [RS_DEPTH];
  logic [RS_DEPTH-1:0] ready_vec;
  logic [RS_DEPTH-1:0] pick_vec;
  logic [IDX_W-1:0]    free_idx;
  logic [IDX_W-1:0]    pick_idx;
  operand_t            in_a;
  operand_t            in_b;

  function automatic operand_t wake(input operand_t op, input cdb_t bus);
    operand_t res;
    res = op;
    if (!op.ready && bus.valid && bus.tag == op.tag) begin
      res.ready = 1'b1;
      res.value = bus.value;
    end
    return res;
  endfunction

  // incoming operands, may catch the cdb in the issue cycle
  always_comb begin
    in_a = wake(src1, cdb);
    if (issue.use_imm) begin
      in_b = '{ready: 1'b1, tag: '0, value: issue.imm};
    end else begin
      in_b = src2;
    end
    in_b = wake(in_b, cdb);
  end

  always_comb begin
    free_idx = '0;
    pick_idx = '0;
    for (int i = 0; i < RS_DEPTH; i++) begin
      ready_vec[i] = slot_valid[i] && slot_a[i].ready && slot_b[i].ready;
    end
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      pick_vec[i] = ready_vec[i] && !(|(slot_older[i] & ready_vec));
      if (!slot_valid[i]) begin
        free_idx = IDX_W'(i);
      end
      if (pick_vec[i]) begin
        pick_idx = IDX_W'(i);
      end
    end
  end

  assign full          = &slot_valid;
  assign alu_req.valid = |pick_vec;
  assign alu_req.op    = slot_op[pick_idx];
  assign alu_req.tag   = slot_tag[pick_idx];
  assign alu_req.a     = slot_a[pick_idx].value;
  assign alu_req.b     = slot_b[pick_idx].value;

  always_ff @(posedge clk_in) begin
    if (rst) begin
      slot_valid <= '0;
    end else begin
      for (int i = 0; i < RS_DEPTH; i++) begin
        if (pick_vec[i]) begin
          slot_valid[i] <= 1'b0;
        end
      end
      if (issue.valid) begin
        slot_valid[free_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      slot_a[i] <= wake(slot_a[i], cdb);
      slot_b[i] <= wake(slot_b[i], cdb);
      // new slot is younger than everything
      if (issue.valid) begin
        slot_older[i][free_idx] <= 1'b0;
      end
    end
    if (issue.valid) begin
      slot_op[free_idx]    <= issue.op;
      slot_tag[free_idx]   <= alloc_tag;
      slot_a[free_idx]     <= in_a;
      slot_b[free_idx]     <= in_b;
      slot_older[free_idx] <= slot_valid & ~pick_vec;
    end
  end

endmodule
